//--- all.f
rtl/vec_pkg.sv
rtl/vec_control.sv
rtl/vec_index_counter.sv
rtl/vec_lane.sv
rtl/vec_result_buffer.sv
rtl/vec_unit.sv
test/vec_checker.sv
test/vec_unit_tb.sv

//--- rtl/vec_control.sv
`timescale 1ns/1ns

module vec_control (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last,
    output logic busy,
    output logic step_clear,
    output logic valid
);

    vec_pkg::vec_state_t state;
    logic                valid_q;

    // start is only taken while idle.
    assign step_clear = (state == vec_pkg::IDLE) && start;
    assign busy       = (state == vec_pkg::RUN);
    assign valid      = valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= vec_pkg::IDLE;
            valid_q <= 1'b0;
        end else begin
            case (state)
                vec_pkg::IDLE: begin
                    if (start) begin
                        state   <= vec_pkg::RUN;
                        valid_q <= 1'b0;  // old result is no longer current.
                    end
                end
                vec_pkg::RUN: begin
                    if (last) begin
                        state   <= vec_pkg::IDLE;
                        valid_q <= 1'b1;
                    end
                end
                default: begin
                    state <= vec_pkg::IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_busy_valid_excl : assert property (
        @(posedge clk) disable iff (rst)
        !(busy && valid)
    );

    // an accepted start gives valid exactly STEPS edges later.
    a_valid_latency : assert property (
        @(posedge clk) disable iff (rst)
        step_clear |=> !valid [*vec_pkg::STEPS] ##1 valid
    );

endmodule

//--- rtl/vec_index_counter.sv
`timescale 1ns/1ns

module vec_index_counter (
    input  logic            clk,
    input  logic            rst,
    input  logic            busy,
    input  logic            step_clear,
    output vec_pkg::index_t index,
    output logic            last
);

    localparam vec_pkg::index_t LAST_INDEX =
        vec_pkg::index_t'(vec_pkg::VECTOR_LEN - vec_pkg::TILING);
    localparam vec_pkg::index_t STEP = vec_pkg::index_t'(vec_pkg::TILING);

    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else if (step_clear) begin
            index <= '0;
        end else if (busy) begin
            index <= index + STEP;
        end
    end

    assign last = (index == LAST_INDEX);  // final group of elements.

    // lanes would read past the vector otherwise.
    a_index_range : assert property (
        @(posedge clk) disable iff (rst)
        busy |-> (index <= LAST_INDEX)
    );

endmodule

//--- rtl/vec_lane.sv
`timescale 1ns/1ns

module vec_lane #(
    parameter int LANE = 0
) (
    input  vec_pkg::vector_t a,
    input  vec_pkg::vector_t b,
    input  vec_pkg::op_t     op,
    input  vec_pkg::index_t  index,
    output vec_pkg::cell_t   sum,
    output logic             overflow,
    output logic             underflow
);

    vec_pkg::index_t                     elem;
    vec_pkg::cell_t                      elem_a;
    vec_pkg::cell_t                      elem_b;
    logic signed [vec_pkg::CELL_WIDTH:0] wide;  // one guard bit above the cell.
    logic                                extra;
    logic                                sign;

    assign elem   = index + vec_pkg::index_t'(LANE);
    assign elem_a = a[elem*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH];
    assign elem_b = b[elem*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH];

    // operands are sign extended into the wider result.
    always_comb begin
        case (op)
            vec_pkg::OP_ADD: wide = elem_a + elem_b;
            vec_pkg::OP_SUB: wide = elem_a - elem_b;
        endcase
    end

    assign extra = wide[vec_pkg::CELL_WIDTH];
    assign sign  = wide[vec_pkg::CELL_WIDTH-1];
    assign sum   = wide[vec_pkg::CELL_WIDTH-1:0];  // wraps modulo 2^CELL_WIDTH.

    // guard and sign disagree only when the true value leaves the cell range.
    assign overflow  = ({extra, sign} == 2'b01);
    assign underflow = ({extra, sign} == 2'b10);

endmodule

//--- rtl/vec_pkg.sv
package vec_pkg;

    // --------------------------------------------------
    // vector geometry
    // --------------------------------------------------
    localparam int VECTOR_LEN  = 6;                    // elements per vector.
    localparam int CELL_WIDTH  = 8;                    // bits per signed element.
    localparam int TILING      = 2;                    // elements handled per clock.
    localparam int STEPS       = VECTOR_LEN / TILING;  // run cycles per operation.
    localparam int INDEX_WIDTH = $clog2(VECTOR_LEN + 1);

    // --------------------------------------------------
    // types
    // --------------------------------------------------
    typedef logic signed [CELL_WIDTH-1:0]     cell_t;
    typedef logic [VECTOR_LEN*CELL_WIDTH-1:0] vector_t;  // element 0 in the low bits.
    typedef logic [INDEX_WIDTH-1:0]           index_t;
    typedef logic                             op_t;

    localparam op_t OP_SUB = 1'b0;
    localparam op_t OP_ADD = 1'b1;

    typedef enum logic {
        IDLE,
        RUN
    } vec_state_t;

endpackage

//--- rtl/vec_result_buffer.sv
`timescale 1ns/1ns

module vec_result_buffer (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    busy,
    input  logic                                    step_clear,
    input  vec_pkg::index_t                         index,
    input  vec_pkg::cell_t [vec_pkg::TILING-1:0]    lane_sum,
    input  logic [vec_pkg::TILING-1:0]              lane_error,
    output vec_pkg::vector_t                        result,
    output logic                                    error
);

    vec_pkg::vector_t result_q;
    logic             error_q;

    // --------------------------------------------------
    // result store
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (busy) begin
            for (int i = 0; i < vec_pkg::TILING; i++) begin
                result_q[(index + i)*vec_pkg::CELL_WIDTH +: vec_pkg::CELL_WIDTH] <= lane_sum[i];
            end
        end
    end

    // --------------------------------------------------
    // sticky error
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            error_q <= 1'b0;
        end else if (step_clear) begin
            error_q <= 1'b0;  // fresh operation.
        end else if (busy) begin
            error_q <= error_q | (|lane_error);
        end
    end

    assign result = result_q;
    assign error  = error_q;

    // the stored vector only moves on a run cycle.
    a_no_idle_write : assert property (
        @(posedge clk) disable iff (rst)
        !busy |=> $stable(result)
    );

endmodule

//--- rtl/vec_unit.sv
`timescale 1ns/1ns

module vec_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  vec_pkg::op_t     op,
    input  vec_pkg::vector_t a,
    input  vec_pkg::vector_t b,
    output vec_pkg::vector_t result,
    output logic             valid,
    output logic             error
);

    logic                                 busy;
    logic                                 step_clear;
    logic                                 last;
    vec_pkg::index_t                      index;
    vec_pkg::cell_t [vec_pkg::TILING-1:0] lane_sum;
    logic [vec_pkg::TILING-1:0]           lane_error;

    // --------------------------------------------------
    // sequencing
    // --------------------------------------------------
    vec_control u_control (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .last       (last),
        .busy       (busy),
        .step_clear (step_clear),
        .valid      (valid)
    );

    vec_index_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .busy       (busy),
        .step_clear (step_clear),
        .index      (index),
        .last       (last)
    );

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    for (genvar g = 0; g < vec_pkg::TILING; g++) begin : g_lane
        logic overflow;
        logic underflow;

        vec_lane #(
            .LANE (g)
        ) u_lane (
            .a         (a),
            .b         (b),
            .op        (op),
            .index     (index),
            .sum       (lane_sum[g]),
            .overflow  (overflow),
            .underflow (underflow)
        );

        assign lane_error[g] = overflow | underflow;
    end

    vec_result_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .busy       (busy),
        .step_clear (step_clear),
        .index      (index),
        .lane_sum   (lane_sum),
        .lane_error (lane_error),
        .result     (result),
        .error      (error)
    );

endmodule

//--- run.sh
#!/bin/sh
# builds the vec_unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module vec_unit_tb -o vec_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/vec_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- test/vec_checker.sv
`timescale 1ns/1ns

module vec_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  vec_pkg::op_t     op,
    input  vec_pkg::vector_t result,
    input  logic             valid,
    input  logic             error,
    input  vec_pkg::vector_t exp_result,
    input  logic             exp_error,
    output int               pass_count,
    output int               fail_count,
    output int               checked
);

    // first edge that sees the raised valid, counted from the start edge.
    localparam int DONE_CYCLE = vec_pkg::STEPS + 1;

    logic             reset_seen;
    logic             pending;
    logic             case_bad;
    int               cycle;
    int               case_no;
    vec_pkg::vector_t want_result;
    logic             want_error;
    vec_pkg::op_t     want_op;

    task automatic report_mismatch(input string name, input string want, input string got);
        $display("mismatch at %0t ns: %s expected %s got %s", $time, name, want, got);
    endtask

    task automatic close_case(input string label);
        if (case_bad) begin
            fail_count++;
            $display("case %0d %s: fail", case_no, label);
        end else begin
            pass_count++;
            $display("case %0d %s: ok", case_no, label);
        end
        checked++;
    endtask

    // --------------------------------------------------
    // per case checks
    // --------------------------------------------------
    task automatic check_reset_state();
        case_bad = 1'b0;
        if (valid !== 1'b0) begin
            report_mismatch("valid", "0", $sformatf("%b", valid));
            case_bad = 1'b1;
        end
        if (error !== 1'b0) begin
            report_mismatch("error", "0", $sformatf("%b", error));
            case_bad = 1'b1;
        end
        if (result !== '0) begin
            report_mismatch("result", $sformatf("%h", vec_pkg::vector_t'(0)),
                            $sformatf("%h", result));
            case_bad = 1'b1;
        end
        close_case("reset");
    endtask

    task automatic check_done();
        if (valid !== 1'b1) begin
            report_mismatch("valid", "1", $sformatf("%b", valid));
            case_bad = 1'b1;
        end
        if (result !== want_result) begin
            report_mismatch("result", $sformatf("%h", want_result), $sformatf("%h", result));
            case_bad = 1'b1;
        end
        if (error !== want_error) begin
            report_mismatch("error", $sformatf("%b", want_error), $sformatf("%b", error));
            case_bad = 1'b1;
        end
        close_case(want_op == vec_pkg::OP_ADD ? "add" : "sub");
    endtask

    // outputs move on the edge, so values seen here are from the edge before.
    always @(posedge clk) begin
        if (rst) begin
            reset_seen = 1'b0;
            pending    = 1'b0;
            case_bad   = 1'b0;
            cycle      = 0;
            case_no    = 0;
            pass_count = 0;
            fail_count = 0;
            checked    = 0;
        end else if (!reset_seen) begin
            reset_seen = 1'b1;
            check_reset_state();
        end else if (pending) begin
            cycle++;
            if (cycle < DONE_CYCLE) begin
                if (valid !== 1'b0) begin  // valid must stay low while running.
                    report_mismatch("valid", "0", $sformatf("%b", valid));
                    case_bad = 1'b1;
                end
            end else begin
                check_done();
                pending = 1'b0;
            end
        end else if (start) begin
            // accepted start, later pulses are ignored until done.
            case_no++;
            pending     = 1'b1;
            case_bad    = 1'b0;
            cycle       = 0;
            want_result = exp_result;
            want_error  = exp_error;
            want_op     = op;
        end
    end

endmodule

//--- test/vec_stimulus.txt
// columns: op (0 sub, 1 add), a, b, expected result, expected error
// vectors are 6 signed bytes, element 0 is the rightmost byte

// plain subtraction and addition
0 000000000000 000000000000 000000000000 0
0 060504030201 010101010101 050403020100 0
1 060504030201 010101010101 070605040302 0
0 000000000000 010101010101 ffffffffffff 0
1 ffffffffffff 010101010101 000000000000 0

// single lane out of range, then a clean op
1 00000000007f 000000000001 000000000080 1
0 000000000080 000000000001 00000000007f 1
0 101010101010 080808080808 080808080808 0

// overflow and underflow in one vector, then a clean op
0 c0408005107f 4030010520ff 80107f00f080 1
1 102030405060 0f0e0d0c0b0a 1f2e3d4c5b6a 0
1 3f01c07f8040 40ffc0808040 7f0080ff0080 1

// range limits that stay inside
0 807fff00807f 807f7f7f0000 00008081807f 0

// errors in the final step only
0 000000000000 800000000000 800000000000 1
1 00ff00000000 008000000000 007f00000000 1

// mixed patterns
1 fedcba987654 0123456789ab ffffffffffff 0
0 fedcba987654 0123456789ab fdb97531eda9 1
0 050a0f14191e 010203040506 04080c101418 0
1 050a0f14191e 010203040506 060c12181e24 0
0 9c3e71d20f88 9c3e71d20f88 000000000000 0
1 9c3e71d20f88 9c3e71d20f88 387ce2a41e10 1

//--- test/vec_unit_tb.sv
`timescale 1ns/1ns

module vec_unit_tb;

    localparam int MAX_TESTS     = 64;
    localparam int FIELDS        = 5;   // op, a, b, result, error.
    localparam int VALID_TIMEOUT = 20;  // cycles.
    localparam int DONE_TIMEOUT  = 20;  // cycles.
    localparam int RESET_CYCLES  = 16;
    localparam vec_pkg::vector_t EMPTY = '1;

    logic             clk;
    logic             rst;
    logic             start;
    vec_pkg::op_t     op;
    vec_pkg::vector_t a;
    vec_pkg::vector_t b;
    vec_pkg::vector_t result;
    logic             valid;
    logic             error;

    vec_pkg::vector_t exp_result;
    logic             exp_error;
    int               pass_count;
    int               fail_count;
    int               checked;

    vec_pkg::vector_t stim_mem [0:MAX_TESTS*FIELDS-1];
    int               num_tests;
    bit               bad_file;

    always #50 clk = ~clk;

    vec_unit uut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .valid  (valid),
        .error  (error)
    );

    vec_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .result     (result),
        .valid      (valid),
        .error      (error),
        .exp_result (exp_result),
        .exp_error  (exp_error),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .checked    (checked)
    );

    // --------------------------------------------------
    // stimulus file
    // --------------------------------------------------
    task automatic load_stimulus();
        for (int i = 0; i < MAX_TESTS*FIELDS; i++) begin
            stim_mem[i] = EMPTY;  // marks words the file did not fill.
        end
        $readmemh("test/vec_stimulus.txt", stim_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && stim_mem[num_tests*FIELDS] != EMPTY) begin
            if (stim_mem[num_tests*FIELDS] > 1) begin
                $display("stimulus case %0d has an op other than 0 or 1", num_tests + 1);
                bad_file = 1'b1;
            end
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no cases found in the stimulus file");
            bad_file = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // one operation
    // --------------------------------------------------
    task automatic run_case(input int n, output bit late);
        int base;
        int waited;
        base = n * FIELDS;
        late = 1'b0;
        @(negedge clk);
        op         = stim_mem[base][0];
        a          = stim_mem[base + 1];
        b          = stim_mem[base + 2];
        exp_result = stim_mem[base + 3];
        exp_error  = stim_mem[base + 4][0];
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // every other case pokes start again while the unit is busy.
        if (n % 2 == 1) begin
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        waited = 0;
        while (!valid && waited < VALID_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!valid) begin
            late = 1'b1;
        end
        repeat (2) @(negedge clk);  // idle gap, operands held.
    endtask

    initial begin
        bit late;
        bit timed_out;
        bit missing;
        int waited;
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        op         = vec_pkg::OP_SUB;
        a          = '0;
        b          = '0;
        exp_result = '0;
        exp_error  = 1'b0;
        bad_file   = 1'b0;
        timed_out  = 1'b0;
        missing    = 1'b0;
        load_stimulus();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        for (int n = 0; n < num_tests; n++) begin
            run_case(n, late);
            if (late) begin
                $display("case %0d: valid never rose within %0d cycles", n + 1, VALID_TIMEOUT);
                timed_out = 1'b1;
                break;
            end
        end

        // the reset check counts as one case.
        waited = 0;
        while (checked < num_tests + 1 && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (checked < num_tests + 1) begin
            $display("checker finished %0d of %0d cases", checked, num_tests + 1);
            missing = 1'b1;
        end

        $display("checks: %0d ok, %0d bad", pass_count, fail_count);
        if (!bad_file && !timed_out && !missing && fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
